// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_gat_wh_core
RTL_TOP   ?= gat_wh_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= source/gat_pkg.sv source/gat_ctrl.sv source/gat_addr_gen.sv \
             source/gat_weight_store.sv source/gat_spmm_row.sv source/gat_dmvm.sv \
             source/gat_fifo.sv source/gat_wh_core.sv
PASS_MSG  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) +incdir+source $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

// File: source/gat_addr_gen.sv
`default_nettype none

`include "gat_settings.svh"

module gat_addr_gen (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire logic                             wgt_step_i,
  input  wire logic                             node_step_i,
  input  wire logic                             len_load_i,
  input  wire logic [gat_pkg::ROW_LEN_W-1:0]    row_len_i,
  input  wire logic                             nz_step_i,
  output logic      [gat_pkg::WEIGHT_ADDR_W-1:0] wgt_addr_o,
  output logic      [gat_pkg::NODE_ADDR_W-1:0]  node_addr_o,
  output logic      [gat_pkg::H_ADDR_W-1:0]     h_addr_o,
  output logic                                  wgt_last_o,
  output logic                                  row_end_o,
  output logic                                  node_last_o
);

  import gat_pkg::*;

  // entries still to read in the current row
  logic [ROW_LEN_W-1:0] remain_q;

  assign wgt_last_o  = (wgt_addr_o == WEIGHT_ADDR_W'(WEIGHT_DEPTH - 1));
  assign node_last_o = (node_addr_o == NODE_ADDR_W'(`GAT_TOTAL_NODES - 1));
  assign row_end_o   = (remain_q == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wgt_addr_o  <= '0;
      node_addr_o <= '0;
    end else begin
      if (wgt_step_i) begin
        wgt_addr_o <= wgt_last_o ? '0 : wgt_addr_o + 1'b1;
      end
      if (node_step_i) begin
        node_addr_o <= node_last_o ? '0 : node_addr_o + 1'b1;
      end
    end
  end

  // h pointer runs across rows since H is packed in node order
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_addr_o <= '0;
      remain_q <= '0;
    end else begin
      if (nz_step_i) begin
        h_addr_o <= h_addr_o + 1'b1;
      end
      if (len_load_i) begin
        remain_q <= row_len_i;
      end else if (nz_step_i) begin
        remain_q <= remain_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/gat_ctrl.sv
`default_nettype none

module gat_ctrl (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic wgt_load_done_i,
  input  wire logic h_data_load_done_i,
  input  wire logic h_node_info_load_done_i,
  input  wire logic wgt_last_i,
  input  wire logic row_end_i,
  input  wire logic node_last_i,
  input  wire logic dmvm_ready_i,
  input  wire logic dmvm_busy_i,
  output logic      wgt_step_o,
  output logic      capture_o,
  output logic      node_step_o,
  output logic      len_load_o,
  output logic      nz_step_o,
  output logic      acc_clear_o,
  output logic      acc_en_o,
  output logic      wh_push_o,
  output logic      gat_done_o
);

  typedef enum logic [3:0] {
    IDLE, LOAD_W, WAIT_H, NODE_RD, NODE_LEN, NZ, DRAIN, WRITE, FINISH
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   capture_q;
  logic   acc_en_q;
  logic   done_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (wgt_load_done_i) begin
          state_d = LOAD_W;
        end
      end
      LOAD_W: begin
        if (wgt_last_i) begin
          state_d = WAIT_H;
        end
      end
      WAIT_H: begin
        if (h_data_load_done_i && h_node_info_load_done_i) begin
          state_d = NODE_RD;
        end
      end
      // node-info read is in flight
      NODE_RD:  state_d = NODE_LEN;
      NODE_LEN: state_d = NZ;
      NZ: begin
        if (row_end_i) begin
          state_d = DRAIN;
        end
      end
      // accumulator holds the finished row
      DRAIN: state_d = WRITE;
      WRITE: begin
        if (dmvm_ready_i) begin
          state_d = node_last_i ? FINISH : NODE_RD;
        end
      end
      FINISH:  state_d = FINISH;
      default: state_d = IDLE;
    endcase
  end

  assign wgt_step_o  = (state_q == LOAD_W);
  assign len_load_o  = (state_q == NODE_LEN);
  assign nz_step_o   = (state_q == NZ) && !row_end_i;
  assign acc_clear_o = (state_q == NODE_RD);
  // write only in a cycle the DMVM can take the row
  assign wh_push_o   = (state_q == WRITE) && dmvm_ready_i;
  assign node_step_o = wh_push_o;

  // data strobes trail the address strobes by the BRAM latency
  assign capture_o  = capture_q;
  assign acc_en_o   = acc_en_q;
  assign gat_done_o = done_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      capture_q <= 1'b0;
      acc_en_q  <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      state_q   <= state_d;
      capture_q <= wgt_step_o;
      acc_en_q  <= nz_step_o;
      if ((state_q == FINISH) && !dmvm_busy_i) begin
        done_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/gat_dmvm.sv
`default_nettype none

`include "gat_settings.svh"

module gat_dmvm (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               wh_push_i,
  input  wire gat_pkg::wh_row_t   wh_row_i,
  input  wire gat_pkg::attn_t     attn_i,
  input  wire logic               fifo_full_i,
  output logic                    dmvm_ready_o,
  output logic                    dmvm_busy_o,
  output gat_pkg::coef_pair_t     coef_o,
  output logic                    coef_wr_o
);

  import gat_pkg::*;

  localparam int NFO    = `GAT_NUM_FEATURE_OUT;
  localparam int PROD_W = `GAT_DATA_WIDTH + `GAT_WH_DATA_WIDTH;

  logic                     stall;
  logic                     s1_vld_q;
  logic                     s2_vld_q;
  logic signed [PROD_W-1:0] self_prod_q [NFO];
  logic signed [PROD_W-1:0] nbr_prod_q [NFO];
  coef_t                    self_sum;
  coef_t                    nbr_sum;
  coef_pair_t               pair_q;

  // output pair blocked by a full FIFO freezes both stages
  assign stall        = s2_vld_q && fifo_full_i;
  assign dmvm_ready_o = !stall;
  assign dmvm_busy_o  = s1_vld_q || s2_vld_q;
  assign coef_wr_o    = s2_vld_q && !fifo_full_i;
  assign coef_o       = pair_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld_q <= 1'b0;
      s2_vld_q <= 1'b0;
    end else if (!stall) begin
      s1_vld_q <= wh_push_i;
      s2_vld_q <= s1_vld_q;
    end
  end

  // stage 1: a[k]*WH[k] and a[NFO+k]*WH[k]
  always_ff @(posedge clk) begin
    if (!stall && wh_push_i) begin
      for (int k = 0; k < NFO; k++) begin
        self_prod_q[k] <= attn_i[k] * wh_row_i[k];
        nbr_prod_q[k]  <= attn_i[NFO + k] * wh_row_i[k];
      end
    end
  end

  always_comb begin
    self_sum = '0;
    nbr_sum  = '0;
    for (int k = 0; k < NFO; k++) begin
      self_sum = self_sum + self_prod_q[k];
      nbr_sum  = nbr_sum + nbr_prod_q[k];
    end
  end

  // stage 2: reduced pair waits here for FIFO space
  always_ff @(posedge clk) begin
    if (!stall && s1_vld_q) begin
      pair_q.self_score <= self_sum;
      pair_q.nbr_score  <= nbr_sum;
    end
  end

endmodule

`default_nettype wire

// File: source/gat_fifo.sv
`default_nettype none

`include "gat_settings.svh"

module gat_fifo #(
  parameter int DEPTH = `GAT_FIFO_DEPTH
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire gat_pkg::coef_pair_t  din_i,
  input  wire logic                 wr_i,
  input  wire logic                 rd_i,
  output gat_pkg::coef_pair_t       dout_o,
  output logic                      full_o,
  output logic                      empty_o
);

  import gat_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  coef_pair_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             wr_en;
  logic             rd_en;

  // wraps at any depth, not only powers of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign wr_en   = wr_i && !full_o;
  assign rd_en   = rd_i && !empty_o;
  // head entry is visible without a read
  assign dout_o  = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= din_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (rd_en) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/gat_pkg.sv
`default_nettype none

`include "gat_settings.svh"

package gat_pkg;

  localparam int COL_IDX_W     = $clog2(`GAT_NUM_FEATURE_IN);
  // row length spans 0 to NUM_FEATURE_IN inclusive
  localparam int ROW_LEN_W     = $clog2(`GAT_NUM_FEATURE_IN + 1);
  localparam int NODE_ADDR_W   = $clog2(`GAT_TOTAL_NODES);
  localparam int H_ADDR_W      = $clog2(`GAT_H_DEPTH);
  // W matrix followed by both attention halves
  localparam int WEIGHT_DEPTH  = `GAT_NUM_FEATURE_IN * `GAT_NUM_FEATURE_OUT
                                 + 2 * `GAT_NUM_FEATURE_OUT;
  localparam int WEIGHT_ADDR_W = $clog2(WEIGHT_DEPTH);

  typedef logic signed [`GAT_DATA_WIDTH-1:0]    data_t;
  typedef logic signed [`GAT_WH_DATA_WIDTH-1:0] wh_lane_t;
  typedef logic signed [`GAT_COEF_WIDTH-1:0]    coef_t;

  typedef struct packed {
    logic [COL_IDX_W-1:0] col_idx;
    data_t                value;
  } h_entry_t;

  // lane 0 in the low bits
  typedef wh_lane_t [`GAT_NUM_FEATURE_OUT-1:0]  wh_row_t;
  typedef data_t [`GAT_NUM_FEATURE_OUT-1:0]     w_row_t;
  // a[0..3] self half, a[4..7] neighbour half
  typedef data_t [2*`GAT_NUM_FEATURE_OUT-1:0]   attn_t;

  typedef struct packed {
    coef_t self_score;
    coef_t nbr_score;
  } coef_pair_t;

endpackage

`default_nettype wire

// File: source/gat_settings.svh
`ifndef GAT_SETTINGS_SVH
`define GAT_SETTINGS_SVH

// H values, weights and attention entries, signed
`define GAT_DATA_WIDTH        8

`define GAT_NUM_FEATURE_IN    16
`define GAT_NUM_FEATURE_OUT   4
`define GAT_TOTAL_NODES       32

// sparse H entries packed back to back
`define GAT_H_DEPTH           256

// one WH lane, signed
`define GAT_WH_DATA_WIDTH     20

// one attention score, signed
`define GAT_COEF_WIDTH        32

`define GAT_FIFO_DEPTH        4

`endif

// File: source/gat_spmm_row.sv
`default_nettype none

`include "gat_settings.svh"

module gat_spmm_row (
  input  wire logic                               clk,
  input  wire logic                               rst_n,
  input  wire logic                               clear_i,
  input  wire logic                               acc_en_i,
  input  wire logic signed [`GAT_DATA_WIDTH-1:0]  value_i,
  input  wire gat_pkg::w_row_t                    w_row_i,
  output gat_pkg::wh_row_t                        wh_row_o
);

  import gat_pkg::*;

  localparam int PROD_W = 2 * `GAT_DATA_WIDTH;

  logic signed [PROD_W-1:0] prod [`GAT_NUM_FEATURE_OUT];
  wh_row_t                  acc_q;

  // value times W[col][k] for every output lane
  always_comb begin
    for (int k = 0; k < `GAT_NUM_FEATURE_OUT; k++) begin
      prod[k] = value_i * w_row_i[k];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (clear_i) begin
      acc_q <= '0;
    end else if (acc_en_i) begin
      for (int k = 0; k < `GAT_NUM_FEATURE_OUT; k++) begin
        acc_q[k] <= acc_q[k] + prod[k];
      end
    end
  end

  assign wh_row_o = acc_q;

endmodule

`default_nettype wire

// File: source/gat_weight_store.sv
`default_nettype none

`include "gat_settings.svh"

module gat_weight_store (
  input  wire logic                               clk,
  input  wire logic                               rst_n,
  input  wire logic                               capture_i,
  input  wire logic [gat_pkg::WEIGHT_ADDR_W-1:0]  wgt_addr_i,
  input  wire logic signed [`GAT_DATA_WIDTH-1:0]  wgt_data_i,
  input  wire logic [gat_pkg::COL_IDX_W-1:0]      col_i,
  output gat_pkg::w_row_t                         w_row_o,
  output gat_pkg::attn_t                          attn_o
);

  import gat_pkg::*;

  localparam int W_WORDS = `GAT_NUM_FEATURE_IN * `GAT_NUM_FEATURE_OUT;
  localparam int LANE_W  = $clog2(`GAT_NUM_FEATURE_OUT);
  localparam int ATTN_W  = $clog2(2 * `GAT_NUM_FEATURE_OUT);

  logic [WEIGHT_ADDR_W-1:0] addr_q;
  logic [COL_IDX_W-1:0]     row_sel;
  logic [LANE_W-1:0]        lane_sel;
  logic [ATTN_W-1:0]        attn_sel;
  w_row_t                   w_q [`GAT_NUM_FEATURE_IN];
  attn_t                    attn_q;

  // address r*NFO+k, attention block starts on an aligned boundary
  assign row_sel  = addr_q[LANE_W +: COL_IDX_W];
  assign lane_sel = addr_q[LANE_W-1:0];
  assign attn_sel = addr_q[ATTN_W-1:0];

  // address of the word now on the BRAM output
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else begin
      addr_q <= wgt_addr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (capture_i) begin
      if (addr_q >= WEIGHT_ADDR_W'(W_WORDS)) begin
        attn_q[attn_sel] <= wgt_data_i;
      end else begin
        w_q[row_sel][lane_sel] <= wgt_data_i;
      end
    end
  end

  assign w_row_o = w_q[col_i];
  assign attn_o  = attn_q;

endmodule

`default_nettype wire

// File: source/gat_wh_core.sv
`default_nettype none

`include "gat_settings.svh"

module gat_wh_core (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic                                wgt_load_done_i,
  input  wire logic                                h_data_load_done_i,
  input  wire logic                                h_node_info_load_done_i,
  input  wire logic signed [`GAT_DATA_WIDTH-1:0]   wgt_bram_dout_i,
  input  wire logic [gat_pkg::ROW_LEN_W-1:0]       h_node_info_dout_i,
  input  wire gat_pkg::h_entry_t                   h_data_dout_i,
  input  wire logic                                coef_rd_i,
  output logic      [gat_pkg::WEIGHT_ADDR_W-1:0]   wgt_bram_addr_o,
  output logic      [gat_pkg::NODE_ADDR_W-1:0]     h_node_info_addr_o,
  output logic      [gat_pkg::H_ADDR_W-1:0]        h_data_addr_o,
  output gat_pkg::wh_row_t                         wh_bram_din_o,
  output logic                                     wh_bram_ena_o,
  output logic      [gat_pkg::NODE_ADDR_W-1:0]     wh_bram_addra_o,
  output gat_pkg::coef_pair_t                      coef_dout_o,
  output logic                                     coef_empty_o,
  output logic                                     gat_done_o
);

  import gat_pkg::*;

  logic                   wgt_step;
  logic                   capture;
  logic                   node_step;
  logic                   len_load;
  logic                   nz_step;
  logic                   acc_clear;
  logic                   acc_en;
  logic                   wh_push;
  logic                   wgt_last;
  logic                   row_end;
  logic                   node_last;
  logic                   dmvm_ready;
  logic                   dmvm_busy;
  logic [NODE_ADDR_W-1:0] node_addr;
  w_row_t                 w_row;
  attn_t                  attn;
  wh_row_t                wh_row;
  coef_pair_t             coef_pair;
  logic                   coef_wr;
  logic                   fifo_full;

  // node index addresses both node info and the WH row
  assign h_node_info_addr_o = node_addr;
  assign wh_bram_addra_o    = node_addr;
  assign wh_bram_din_o      = wh_row;
  assign wh_bram_ena_o      = wh_push;

  gat_ctrl u_gat_ctrl (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .wgt_load_done_i         (wgt_load_done_i),
    .h_data_load_done_i      (h_data_load_done_i),
    .h_node_info_load_done_i (h_node_info_load_done_i),
    .wgt_last_i              (wgt_last),
    .row_end_i               (row_end),
    .node_last_i             (node_last),
    .dmvm_ready_i            (dmvm_ready),
    .dmvm_busy_i             (dmvm_busy),
    .wgt_step_o              (wgt_step),
    .capture_o               (capture),
    .node_step_o             (node_step),
    .len_load_o              (len_load),
    .nz_step_o               (nz_step),
    .acc_clear_o             (acc_clear),
    .acc_en_o                (acc_en),
    .wh_push_o               (wh_push),
    .gat_done_o              (gat_done_o)
  );

  gat_addr_gen u_gat_addr_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .wgt_step_i  (wgt_step),
    .node_step_i (node_step),
    .len_load_i  (len_load),
    .row_len_i   (h_node_info_dout_i),
    .nz_step_i   (nz_step),
    .wgt_addr_o  (wgt_bram_addr_o),
    .node_addr_o (node_addr),
    .h_addr_o    (h_data_addr_o),
    .wgt_last_o  (wgt_last),
    .row_end_o   (row_end),
    .node_last_o (node_last)
  );

  gat_weight_store u_gat_weight_store (
    .clk        (clk),
    .rst_n      (rst_n),
    .capture_i  (capture),
    .wgt_addr_i (wgt_bram_addr_o),
    .wgt_data_i (wgt_bram_dout_i),
    .col_i      (h_data_dout_i.col_idx),
    .w_row_o    (w_row),
    .attn_o     (attn)
  );

  gat_spmm_row u_gat_spmm_row (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear_i  (acc_clear),
    .acc_en_i (acc_en),
    .value_i  (h_data_dout_i.value),
    .w_row_i  (w_row),
    .wh_row_o (wh_row)
  );

  gat_dmvm u_gat_dmvm (
    .clk          (clk),
    .rst_n        (rst_n),
    .wh_push_i    (wh_push),
    .wh_row_i     (wh_row),
    .attn_i       (attn),
    .fifo_full_i  (fifo_full),
    .dmvm_ready_o (dmvm_ready),
    .dmvm_busy_o  (dmvm_busy),
    .coef_o       (coef_pair),
    .coef_wr_o    (coef_wr)
  );

  gat_fifo #(
    .DEPTH (`GAT_FIFO_DEPTH)
  ) u_gat_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .din_i   (coef_pair),
    .wr_i    (coef_wr),
    .rd_i    (coef_rd_i),
    .dout_o  (coef_dout_o),
    .full_o  (fifo_full),
    .empty_o (coef_empty_o)
  );

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/gat_pkg.sv
source/gat_ctrl.sv
source/gat_addr_gen.sv
source/gat_weight_store.sv
source/gat_spmm_row.sv
source/gat_dmvm.sv
source/gat_fifo.sv
source/gat_wh_core.sv
test/tb_gat_wh_core.sv

// File: test/tb_gat_wh_core.sv
`default_nettype none

`include "gat_settings.svh"

module tb_gat_wh_core;

  timeunit 1ns;
  timeprecision 1ps;

  import gat_pkg::*;

  localparam int NODES       = `GAT_TOTAL_NODES;
  localparam int NFI         = `GAT_NUM_FEATURE_IN;
  localparam int NFO         = `GAT_NUM_FEATURE_OUT;
  localparam int FIFO_DEPTH  = `GAT_FIFO_DEPTH;
  localparam int ATTN_BASE   = NFI * NFO;
  localparam int WAIT_LIMIT  = 4000;
  localparam int PROMPT_ROWS = 8;
  // two pipeline cycles to the FIFO write and one more for the pop
  localparam int POP_LATENCY = 3;
  // a quiet stretch longer than the slowest row means a stall
  localparam int QUIET_LIMIT = 40;
  localparam int HOLD_CYCLES = 60;

  logic                              clk = 1'b0;
  logic                              rst_n;
  logic                              wgt_load_done_i;
  logic                              h_data_load_done_i;
  logic                              h_node_info_load_done_i;
  logic signed [`GAT_DATA_WIDTH-1:0] wgt_bram_dout_i = '0;
  logic [ROW_LEN_W-1:0]              h_node_info_dout_i = '0;
  h_entry_t                          h_data_dout_i = '0;
  logic                              coef_rd_i;
  logic [WEIGHT_ADDR_W-1:0]          wgt_bram_addr_o;
  logic [NODE_ADDR_W-1:0]            h_node_info_addr_o;
  logic [H_ADDR_W-1:0]               h_data_addr_o;
  wh_row_t                           wh_bram_din_o;
  logic                              wh_bram_ena_o;
  logic [NODE_ADDR_W-1:0]            wh_bram_addra_o;
  coef_pair_t                        coef_dout_o;
  logic                              coef_empty_o;
  logic                              gat_done_o;

  // BRAM contents
  logic signed [`GAT_DATA_WIDTH-1:0] wgt_mem [2**WEIGHT_ADDR_W];
  logic [ROW_LEN_W-1:0]              node_len [NODES];
  h_entry_t                          h_mem [`GAT_H_DEPTH];

  wh_row_t    ref_wh [NODES];
  coef_pair_t ref_pair [NODES];
  wh_row_t    got_wh [NODES];
  coef_pair_t got_pair [NODES];
  int         wh_cycle [NODES];
  int         pop_cycle [NODES];

  int     cycle_count  = 0;
  int     wh_count     = 0;
  int     pair_count   = 0;
  int     quiet_cycles = 0;
  int     value_errors = 0;
  int     other_errors = 0;
  integer seed         = 32'h139057fa;

  gat_wh_core u_gat_wh_core (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .wgt_load_done_i         (wgt_load_done_i),
    .h_data_load_done_i      (h_data_load_done_i),
    .h_node_info_load_done_i (h_node_info_load_done_i),
    .wgt_bram_dout_i         (wgt_bram_dout_i),
    .h_node_info_dout_i      (h_node_info_dout_i),
    .h_data_dout_i           (h_data_dout_i),
    .coef_rd_i               (coef_rd_i),
    .wgt_bram_addr_o         (wgt_bram_addr_o),
    .h_node_info_addr_o      (h_node_info_addr_o),
    .h_data_addr_o           (h_data_addr_o),
    .wh_bram_din_o           (wh_bram_din_o),
    .wh_bram_ena_o           (wh_bram_ena_o),
    .wh_bram_addra_o         (wh_bram_addra_o),
    .coef_dout_o             (coef_dout_o),
    .coef_empty_o            (coef_empty_o),
    .gat_done_o              (gat_done_o)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // external BRAMs with one cycle read latency
  always @(posedge clk) begin
    wgt_bram_dout_i    <= wgt_mem[wgt_bram_addr_o];
    h_node_info_dout_i <= node_len[h_node_info_addr_o];
    h_data_dout_i      <= h_mem[h_data_addr_o];
  end

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // WH writes and FIFO pops seen with pre-edge values
  always @(posedge clk) begin
    if (rst_n) begin
      cycle_count++;
      if (wh_bram_ena_o) begin
        quiet_cycles = 0;
        if (wh_count >= NODES) begin
          other_errors++;
          $display("WH write seen after all %0d rows were written", NODES);
        end else begin
          check_value("wh_bram_addra_o", wh_bram_addra_o, wh_count);
          got_wh[wh_count]   = wh_bram_din_o;
          wh_cycle[wh_count] = cycle_count;
          wh_count++;
        end
      end else begin
        quiet_cycles++;
      end
      if (coef_rd_i && !coef_empty_o) begin
        if (pair_count >= NODES) begin
          other_errors++;
          $display("score pair popped after all %0d pairs were read", NODES);
        end else begin
          got_pair[pair_count]  = coef_dout_o;
          pop_cycle[pair_count] = cycle_count;
          pair_count++;
        end
      end
    end
  end

  task automatic fill_memories();
    logic [31:0] r;
    for (int a = 0; a < 2**WEIGHT_ADDR_W; a++) begin
      r = $random(seed);
      wgt_mem[a] = r[`GAT_DATA_WIDTH-1:0];
    end
    for (int n = 0; n < NODES; n++) begin
      r = $random(seed);
      node_len[n] = ROW_LEN_W'(r[2:0]);
    end
    // empty rows and full rows at both ends
    node_len[0]       = '0;
    node_len[1]       = ROW_LEN_W'(NFI);
    node_len[2]       = ROW_LEN_W'(NFI);
    node_len[5]       = '0;
    node_len[NODES-1] = ROW_LEN_W'(NFI);
    for (int i = 0; i < `GAT_H_DEPTH; i++) begin
      r = $random(seed);
      h_mem[i].col_idx = r[COL_IDX_W-1:0];
      h_mem[i].value   = r[8 +: `GAT_DATA_WIDTH];
    end
    // node 1 covers every column and node 2 reuses four
    for (int i = 0; i < NFI; i++) begin
      h_mem[i].col_idx       = COL_IDX_W'(i);
      h_mem[NFI + i].col_idx = COL_IDX_W'(i % 4);
    end
  endtask

  task automatic build_reference();
    int       ptr;
    int       idx;
    longint   lane [NFO];
    longint   self_sum;
    longint   nbr_sum;
    h_entry_t e;
    ptr = 0;
    for (int n = 0; n < NODES; n++) begin
      for (int k = 0; k < NFO; k++) begin
        lane[k] = 0;
      end
      for (int i = 0; i < int'(node_len[n]); i++) begin
        e = h_mem[ptr + i];
        for (int k = 0; k < NFO; k++) begin
          idx     = int'(e.col_idx) * NFO + k;
          lane[k] = lane[k] + longint'(e.value) * longint'(wgt_mem[idx]);
        end
      end
      ptr      = ptr + int'(node_len[n]);
      self_sum = 0;
      nbr_sum  = 0;
      for (int k = 0; k < NFO; k++) begin
        ref_wh[n][k] = wh_lane_t'(lane[k]);
        self_sum     = self_sum + longint'(wgt_mem[ATTN_BASE + k]) * lane[k];
        nbr_sum      = nbr_sum + longint'(wgt_mem[ATTN_BASE + NFO + k]) * lane[k];
      end
      ref_pair[n].self_score = coef_t'(self_sum);
      ref_pair[n].nbr_score  = coef_t'(nbr_sum);
    end
  endtask

  task automatic apply_reset();
    rst_n                   = 1'b0;
    wgt_load_done_i         = 1'b0;
    h_data_load_done_i      = 1'b0;
    h_node_info_load_done_i = 1'b0;
    coef_rd_i               = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic test_reset_state();
    repeat (20) begin
      @(negedge clk);
      check_value("wh_bram_ena_o", wh_bram_ena_o, 1'b0);
      check_value("gat_done_o", gat_done_o, 1'b0);
      check_value("coef_empty_o", coef_empty_o, 1'b1);
    end
  endtask

  task automatic test_rows_and_prompt_scores();
    int waited;
    @(posedge clk);
    wgt_load_done_i <= 1'b1;
    coef_rd_i       <= 1'b1;
    // H arrives well after the weight load
    repeat (90) @(posedge clk);
    h_data_load_done_i <= 1'b1;
    // node info still pending keeps the layer waiting
    repeat (20) @(negedge clk);
    check_value("WH writes before H loaded", wh_count, 0);
    @(posedge clk);
    h_node_info_load_done_i <= 1'b1;
    waited = 0;
    while (pair_count < PROMPT_ROWS && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (pair_count < PROMPT_ROWS) begin
      other_errors++;
      $display("timeout: fewer than %0d score pairs read while draining", PROMPT_ROWS);
    end else begin
      for (int n = 0; n < PROMPT_ROWS; n++) begin
        check_value($sformatf("wh_bram_din_o node %0d", n), got_wh[n], ref_wh[n]);
        check_value($sformatf("coef_dout_o node %0d", n), got_pair[n], ref_pair[n]);
        check_value($sformatf("pop latency node %0d", n), pop_cycle[n] - wh_cycle[n],
                    POP_LATENCY);
      end
    end
  endtask

  task automatic test_back_pressure();
    int waited;
    int stall_rows;
    int pending;
    @(posedge clk);
    coef_rd_i <= 1'b0;
    waited = 0;
    while (quiet_cycles < QUIET_LIMIT && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (quiet_cycles < QUIET_LIMIT) begin
      other_errors++;
      $display("timeout: WH writes never paused with the FIFO left unread");
    end else begin
      stall_rows = wh_count;
      pending    = wh_count - pair_count;
      // FIFO full plus one or two rows held in the DMVM stages
      if (pending < FIFO_DEPTH + 1 || pending > FIFO_DEPTH + 2) begin
        other_errors++;
        $display("%0d rows pending at the stall, expected %0d or %0d", pending,
                 FIFO_DEPTH + 1, FIFO_DEPTH + 2);
      end
      check_value("coef_empty_o", coef_empty_o, 1'b0);
      repeat (HOLD_CYCLES) @(negedge clk);
      check_value("WH write count during stall", wh_count, stall_rows);
    end
    @(posedge clk);
    coef_rd_i <= 1'b1;
  endtask

  task automatic test_completion();
    int waited;
    waited = 0;
    while (!gat_done_o && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!gat_done_o) begin
      other_errors++;
      $display("timeout: gat_done_o never rose");
    end else begin
      check_value("WH rows before gat_done_o", wh_count, NODES);
      // reads keep at most one pair in the FIFO by now
      check_value("pairs written before gat_done_o", pair_count + int'(!coef_empty_o),
                  NODES);
    end
    waited = 0;
    while (pair_count < NODES && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (pair_count < NODES) begin
      other_errors++;
      $display("timeout: only %0d of %0d score pairs delivered", pair_count, NODES);
    end
    for (int n = PROMPT_ROWS; n < wh_count; n++) begin
      check_value($sformatf("wh_bram_din_o node %0d", n), got_wh[n], ref_wh[n]);
    end
    for (int n = PROMPT_ROWS; n < pair_count; n++) begin
      check_value($sformatf("coef_dout_o node %0d", n), got_pair[n], ref_pair[n]);
    end
    // nothing more may arrive once the layer is done
    repeat (16) @(negedge clk);
    check_value("WH rows written", wh_count, NODES);
    check_value("score pairs read", pair_count, NODES);
    check_value("gat_done_o", gat_done_o, 1'b1);
    check_value("coef_empty_o", coef_empty_o, 1'b1);
  endtask

  task automatic finish_run();
    $display("error counts: %0d value mismatches, %0d other errors", value_errors,
             other_errors);
    if (value_errors + other_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  initial begin
    fill_memories();
    build_reference();
    apply_reset();
    test_reset_state();
    test_rows_and_prompt_scores();
    test_back_pressure();
    test_completion();
    finish_run();
  end

endmodule

`default_nettype wire
